/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic               clk_i,
  input  logic               arst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  isa_pkg::ir_t       in_ir,
  input  logic               stall,
  input  pipe_pkg::fwd_sel_t sel_a,
  input  pipe_pkg::fwd_sel_t sel_b,
  input  pipe_pkg::fwd_sel_t sel_s,
  output isa_pkg::reg_addr_t rd_addr_a,
  output isa_pkg::reg_addr_t rd_addr_b,
  output isa_pkg::reg_addr_t rd_addr_s,
  input  isa_pkg::data_t     rd_data_a,
  input  isa_pkg::data_t     rd_data_b,
  input  isa_pkg::data_t     rd_data_s,
  output isa_pkg::ir_t       if_ir,
  output isa_pkg::ir_t       id_ir,
  output pipe_pkg::id_exe_t  id_exe
);
  import isa_pkg::*;

  ir_t   id_q;  // if/id register
  data_t op_b;

  assign in_ready  = !stall;
  assign if_ir     = in_valid ? in_ir : IR_BUBBLE;
  assign id_ir     = id_q;
  assign rd_addr_a = ir_rb(id_q);
  assign rd_addr_b = ir_rc(id_q);
  assign rd_addr_s = ir_ra(id_q);
  assign op_b      = (ir_type(id_q) == T_ALU && ir_imm_sel(id_q)) ? ir_imm(id_q) : rd_data_b;

  always_ff @(posedge clk_i or negedge arst_n)
  begin
    if (!arst_n)
    begin
      id_q   <= IR_BUBBLE;
      id_exe <= '0;
    end
    else
    begin
      id_q   <= stall ? IR_BUBBLE : if_ir;  // refused word stays at the port
      id_exe <= '{ir: id_q, a: rd_data_a, b: op_b, s: rd_data_s,
                  sel_a: sel_a, sel_b: sel_b, sel_s: sel_s};
    end
  end

endmodule

/* hw/exe_stage.sv */
`timescale 1ns/1ps
`include "pipe_params.svh"

module exe_stage (
  input  logic               clk_i,
  input  logic               arst_n,
  input  pipe_pkg::id_exe_t  id_exe,
  input  isa_pkg::data_t     mem_result,
  input  pipe_pkg::wb_t      wb,
  output isa_pkg::ir_t       exe_ir,
  output logic               exe_write,
  output pipe_pkg::exe_mem_t exe_mem
);
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int SHAMT_W = $clog2(`PIPE_DATA_W);

  data_t    wb_q;  // data of the previous write-back
  data_t    opa, opb, sdata, result;
  ir_type_t t;

  // selects were made one cycle ago, so each producer has moved one stage on
  function automatic data_t fwd(input fwd_sel_t sel, input data_t v);
    data_t r;
    case (sel)
      FWD_EXE: r = mem_result;
      FWD_MEM: r = wb.data;
      FWD_WB:  r = wb_q;
      default: r = v;
    endcase
    return r;
  endfunction

  function automatic data_t alu(input alu_op_t op, input data_t x, input data_t y);
    data_t r;
    case (op)
      OP_ADD:  r = x + y;
      OP_SUB:  r = x - y;
      OP_AND:  r = x & y;
      OP_OR:   r = x | y;
      OP_XOR:  r = x ^ y;
      OP_SHL:  r = x << y[SHAMT_W-1:0];
      OP_SHR:  r = x >> y[SHAMT_W-1:0];
      default: r = '0;
    endcase
    return r;
  endfunction

  assign exe_ir    = id_exe.ir;
  assign t         = ir_type(id_exe.ir);
  assign exe_write = (id_exe.ir != IR_BUBBLE) && (t inside {T_ALU, T_MOV, T_LDI, T_LOAD});

  always_comb
  begin
    opa   = fwd(id_exe.sel_a, id_exe.a);
    opb   = fwd(id_exe.sel_b, id_exe.b);
    sdata = fwd(id_exe.sel_s, id_exe.s);
    case (t)
      T_ALU:           result = alu(ir_alu_op(id_exe.ir), opa, opb);
      T_MOV:           result = opa;
      T_LDI:           result = ir_imm(id_exe.ir);
      T_LOAD, T_STORE: result = ir_immf(id_exe.ir) ? ir_imm(id_exe.ir) : opa + ir_imm(id_exe.ir);
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wb_q    <= '0;
      exe_mem <= '0;
    end
    else
    begin
      wb_q    <= wb.data;
      exe_mem <= '{ir: id_exe.ir, result: result, sdata: sdata, write: exe_write};
    end
  end

endmodule

/* hw/hazard.sv */
`timescale 1ns/1ps

module hazard (
  input  logic               clk_i,
  input  logic               arst_n,
  input  isa_pkg::ir_t       if_ir,
  input  isa_pkg::ir_t       id_ir,
  input  isa_pkg::ir_t       exe_ir,
  input  isa_pkg::ir_t       mem_ir,
  input  logic               exe_write,
  input  logic               mem_write,
  input  pipe_pkg::wb_t      wb,
  output logic               stall,
  output pipe_pkg::fwd_sel_t sel_a,
  output pipe_pkg::fwd_sel_t sel_b,
  output pipe_pkg::fwd_sel_t sel_s
);
  import isa_pkg::*;
  import pipe_pkg::*;

  reg_addr_t load_dst;
  logic      if_uses_load;

  function automatic logic reads_rb(input ir_t ir);
    logic r;
    case (ir_type(ir))
      T_ALU, T_MOV:    r = 1'b1;
      T_LOAD, T_STORE: r = !ir_immf(ir);
      default:         r = 1'b0;
    endcase
    return r && (ir != IR_BUBBLE);
  endfunction

  function automatic logic reads_rc(input ir_t ir);
    return (ir_type(ir) == T_ALU) && !ir_imm_sel(ir) && (ir != IR_BUBBLE);
  endfunction

  function automatic logic reads_ra(input ir_t ir);
    return ir_type(ir) == T_STORE;  // store data
  endfunction

  // youngest producer wins
  function automatic fwd_sel_t pick(input reg_addr_t r);
    fwd_sel_t s;
    s = FWD_NONE;
    if (exe_write && ir_ra(exe_ir) == r)
      s = FWD_EXE;
    else if (mem_write && ir_ra(mem_ir) == r)
      s = FWD_MEM;
    else if (wb.write && wb.addr == r)
      s = FWD_WB;
    return s;
  endfunction

  always_comb
  begin
    sel_a = reads_rb(id_ir) ? pick(ir_rb(id_ir)) : FWD_NONE;
    sel_b = reads_rc(id_ir) ? pick(ir_rc(id_ir)) : FWD_NONE;
    sel_s = reads_ra(id_ir) ? pick(ir_ra(id_ir)) : FWD_NONE;
  end

  // ************************************************************
  // load-use
  // ************************************************************

  assign load_dst = ir_ra(id_ir);

  assign if_uses_load = (reads_rb(if_ir) && ir_rb(if_ir) == load_dst) ||
                        (reads_rc(if_ir) && ir_rc(if_ir) == load_dst) ||
                        (reads_ra(if_ir) && ir_ra(if_ir) == load_dst);

  assign stall = (ir_type(id_ir) == T_LOAD) && (if_ir != IR_BUBBLE) && if_uses_load;

endmodule

/* hw/isa_pkg.sv */
`include "pipe_params.svh"

package isa_pkg;

  typedef logic [63:0]                      ir_t;
  typedef logic [$clog2(`PIPE_REG_CNT)-1:0] reg_addr_t;
  typedef logic [`PIPE_DATA_W-1:0]          data_t;
  typedef logic [3:0]                       op_field_t;
  typedef logic [31:0]                      imm_t;

  typedef enum logic [3:0] {
    T_ALU   = 4'd0,
    T_MOV   = 4'd1,
    T_LDI   = 4'd2,
    T_LOAD  = 4'd3,
    T_STORE = 4'd4
  } ir_type_t;

  typedef enum logic [2:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR
  } alu_op_t;

  localparam ir_t IR_BUBBLE = '0;

  // ************************************************************
  // field access
  // ************************************************************

  function automatic ir_type_t ir_type(input ir_t ir);
    return ir_type_t'(ir[31:28]);
  endfunction

  function automatic op_field_t ir_op(input ir_t ir);
    return ir[27:24];
  endfunction

  function automatic alu_op_t ir_alu_op(input ir_t ir);
    return alu_op_t'(ir[26:24]);
  endfunction

  function automatic logic ir_imm_sel(input ir_t ir);
    return ir[27];  // op bit 3, immediate replaces rc
  endfunction

  function automatic reg_addr_t ir_ra(input ir_t ir);
    return ir[23:20];
  endfunction

  function automatic reg_addr_t ir_rb(input ir_t ir);
    return ir[19:16];
  endfunction

  function automatic reg_addr_t ir_rc(input ir_t ir);
    return ir[15:12];
  endfunction

  function automatic logic ir_immf(input ir_t ir);
    return ir[0];  // absolute address for load/store
  endfunction

  function automatic imm_t ir_imm(input ir_t ir);
    return ir[63:32];
  endfunction

endpackage

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`include "pipe_params.svh"

module mem_stage #(
  parameter int DMEM_DEPTH = `PIPE_DMEM_DEPTH
) (
  input  logic               clk_i,
  input  logic               arst_n,
  input  pipe_pkg::exe_mem_t exe_mem,
  output isa_pkg::ir_t       mem_ir,
  output logic               mem_write,
  output isa_pkg::data_t     mem_result,
  output pipe_pkg::wb_t      wb
);
  import isa_pkg::*;

  localparam int AW = $clog2(DMEM_DEPTH);

  data_t         dmem [DMEM_DEPTH];
  logic [AW-1:0] addr;  // address wraps at the depth
  ir_type_t      t;

  assign t          = ir_type(exe_mem.ir);
  assign addr       = exe_mem.result[AW-1:0];
  assign mem_ir     = exe_mem.ir;
  assign mem_write  = exe_mem.write;
  assign mem_result = (t == T_LOAD) ? dmem[addr] : exe_mem.result;

  always_ff @(posedge clk_i or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < DMEM_DEPTH; i++)
        dmem[i] <= '0;
    end
    else if (t == T_STORE)
    begin
      dmem[addr] <= exe_mem.sdata;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n)
  begin
    if (!arst_n)
      wb <= '0;
    else
      wb <= '{write: exe_mem.write, addr: ir_ra(exe_mem.ir), data: mem_result};
  end

endmodule

/* hw/pipe_params.svh */
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// ************************************************************
// pipeline sizing
// ************************************************************

`define PIPE_REG_CNT    16  // architectural registers
`define PIPE_DATA_W     32  // datapath width
`define PIPE_DMEM_DEPTH 64  // data memory words, power of two

`endif

/* hw/pipe_pkg.sv */
package pipe_pkg;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_MEM  = 2'd1,
    FWD_EXE  = 2'd2,
    FWD_WB   = 2'd3
  } fwd_sel_t;

  // ************************************************************
  // stage payloads
  // ************************************************************

  typedef struct packed {
    isa_pkg::ir_t   ir;
    isa_pkg::data_t a;      // rb value
    isa_pkg::data_t b;      // rc value or immediate
    isa_pkg::data_t s;      // store data from ra
    fwd_sel_t       sel_a;
    fwd_sel_t       sel_b;
    fwd_sel_t       sel_s;
  } id_exe_t;

  typedef struct packed {
    isa_pkg::ir_t   ir;
    isa_pkg::data_t result;  // alu result or memory address
    isa_pkg::data_t sdata;
    logic           write;
  } exe_mem_t;

  typedef struct packed {
    logic              write;
    isa_pkg::reg_addr_t addr;
    isa_pkg::data_t    data;
  } wb_t;

endpackage

/* hw/pipe_top.sv */
`timescale 1ns/1ps

module pipe_top (
  input  logic          clk_i,
  input  logic          arst_n,
  input  logic          in_valid,
  input  isa_pkg::ir_t  in_ir,
  output logic          in_ready,
  output pipe_pkg::wb_t wb
);
  import isa_pkg::*;
  import pipe_pkg::*;

  ir_t       if_ir, id_ir, exe_ir, mem_ir;
  logic      exe_write, mem_write;
  logic      stall;
  fwd_sel_t  sel_a, sel_b, sel_s;
  reg_addr_t rd_addr_a, rd_addr_b, rd_addr_s;
  data_t     rd_data_a, rd_data_b, rd_data_s;
  data_t     mem_result;
  id_exe_t   id_exe;
  exe_mem_t  exe_mem;

  // ************************************************************
  // fetch / decode, hazards and registers
  // ************************************************************

  decode_stage u_decode (
    .clk_i     (clk_i),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_ir     (in_ir),
    .stall     (stall),
    .sel_a     (sel_a),
    .sel_b     (sel_b),
    .sel_s     (sel_s),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_addr_s (rd_addr_s),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .rd_data_s (rd_data_s),
    .if_ir     (if_ir),
    .id_ir     (id_ir),
    .id_exe    (id_exe)
  );

  hazard u_hazard (
    .clk_i     (clk_i),
    .arst_n    (arst_n),
    .if_ir     (if_ir),
    .id_ir     (id_ir),
    .exe_ir    (exe_ir),
    .mem_ir    (mem_ir),
    .exe_write (exe_write),
    .mem_write (mem_write),
    .wb        (wb),
    .stall     (stall),
    .sel_a     (sel_a),
    .sel_b     (sel_b),
    .sel_s     (sel_s)
  );

  reg_file u_regs (
    .clk_i     (clk_i),
    .arst_n    (arst_n),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_addr_s (rd_addr_s),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .rd_data_s (rd_data_s),
    .wb        (wb)
  );

  // ************************************************************
  // execute and memory
  // ************************************************************

  exe_stage u_exe (
    .clk_i      (clk_i),
    .arst_n     (arst_n),
    .id_exe     (id_exe),
    .mem_result (mem_result),
    .wb         (wb),
    .exe_ir     (exe_ir),
    .exe_write  (exe_write),
    .exe_mem    (exe_mem)
  );

  mem_stage u_mem (
    .clk_i      (clk_i),
    .arst_n     (arst_n),
    .exe_mem    (exe_mem),
    .mem_ir     (mem_ir),
    .mem_write  (mem_write),
    .mem_result (mem_result),
    .wb         (wb)
  );

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "pipe_params.svh"

module reg_file (
  input  logic               clk_i,
  input  logic               arst_n,
  input  isa_pkg::reg_addr_t rd_addr_a,
  input  isa_pkg::reg_addr_t rd_addr_b,
  input  isa_pkg::reg_addr_t rd_addr_s,
  output isa_pkg::data_t     rd_data_a,
  output isa_pkg::data_t     rd_data_b,
  output isa_pkg::data_t     rd_data_s,
  input  pipe_pkg::wb_t      wb
);
  import isa_pkg::*;

  data_t regs [`PIPE_REG_CNT];

  always_ff @(posedge clk_i or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < `PIPE_REG_CNT; i++)
        regs[i] <= '0;
    end
    else if (wb.write)
    begin
      regs[wb.addr] <= wb.data;
    end
  end

  assign rd_data_a = regs[rd_addr_a];  // old value during a write
  assign rd_data_b = regs[rd_addr_b];
  assign rd_data_s = regs[rd_addr_s];

endmodule

/* list.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/hazard.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/exe_stage.sv
hw/mem_stage.sv
hw/pipe_top.sv
verification/pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module pipe_tb -f list.f -o pipe_sim
./obj_dir/pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"

/* verification/pipe_tb.sv */
`timescale 1ns/1ps
`include "pipe_params.svh"

module pipe_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int MAW = $clog2(`PIPE_DMEM_DEPTH);

  logic   clk_i;
  logic   arst_n;
  logic   in_valid;
  ir_t    in_ir;
  logic   in_ready;
  wb_t    wb;

  integer seed;
  int     checks, errors, stalls;
  int     chk_mark, err_mark, stall_mark;
  ir_t    id_word;  // word the model expects in id
  data_t  mregs [`PIPE_REG_CNT];
  data_t  mmem [`PIPE_DMEM_DEPTH];
  wb_t    exp_q [$];

  pipe_top dut (
    .clk_i    (clk_i),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ir    (in_ir),
    .in_ready (in_ready),
    .wb       (wb)
  );

  always #10 clk_i = ~clk_i;

  // ************************************************************
  // stimulus helpers
  // ************************************************************

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic reg_addr_t rnd_reg(input int unsigned n);
    return reg_addr_t'(rnd(n));
  endfunction

  function automatic data_t rnd_word();
    return data_t'($random(seed));
  endfunction

  function automatic ir_t enc(input ir_type_t t, input op_field_t op, input reg_addr_t ra,
                              input reg_addr_t rb, input reg_addr_t rc, input logic immf,
                              input data_t imm);
    ir_t w;
    w = {imm, t, op, ra, rb, rc, 11'd0, immf};
    if (w == '0)
      w[0] = 1'b1;  // never send a bubble by accident
    return w;
  endfunction

  function automatic ir_t rand_ir(input ir_type_t t, input int unsigned nreg);
    return enc(t, {1'(rnd(2)), 3'(rnd(7))}, rnd_reg(nreg), rnd_reg(nreg), rnd_reg(nreg),
               1'(rnd(2)), rnd_word());
  endfunction

  // ************************************************************
  // ISA model
  // ************************************************************

  function automatic logic reads_rb(input ir_t w);
    ir_type_t t;
    t = ir_type_t'(w[31:28]);
    return (t == T_ALU) || (t == T_MOV) || ((t == T_LOAD || t == T_STORE) && !w[0]);
  endfunction

  function automatic logic reads_rc(input ir_t w);
    return (ir_type_t'(w[31:28]) == T_ALU) && !w[27];
  endfunction

  function automatic logic reads_ra(input ir_t w);
    return ir_type_t'(w[31:28]) == T_STORE;
  endfunction

  function automatic logic load_use(input ir_t id_w, input ir_t if_w);
    reg_addr_t d;
    logic      hit;
    d   = id_w[23:20];
    hit = (reads_rb(if_w) && if_w[19:16] == d) || (reads_rc(if_w) && if_w[15:12] == d) ||
          (reads_ra(if_w) && if_w[23:20] == d);
    return (ir_type_t'(id_w[31:28]) == T_LOAD) && (if_w != '0) && hit;
  endfunction

  function automatic data_t model_alu(input logic [2:0] op, input data_t x, input data_t y);
    case (alu_op_t'(op))
      OP_ADD:  return x + y;
      OP_SUB:  return x - y;
      OP_AND:  return x & y;
      OP_OR:   return x | y;
      OP_XOR:  return x ^ y;
      OP_SHL:  return x << (y % `PIPE_DATA_W);
      default: return x >> (y % `PIPE_DATA_W);
    endcase
  endfunction

  task automatic push_wb(input reg_addr_t ra, input data_t v);
    mregs[ra] = v;
    exp_q.push_back('{write: 1'b1, addr: ra, data: v});
  endtask

  task automatic model_exec(input ir_t w);
    reg_addr_t      ra;
    data_t          imm, a, b;
    logic [MAW-1:0] addr;
    ra   = w[23:20];
    imm  = w[63:32];
    a    = mregs[w[19:16]];
    b    = w[27] ? imm : mregs[w[15:12]];
    addr = w[0] ? MAW'(imm % `PIPE_DMEM_DEPTH) : MAW'((a + imm) % `PIPE_DMEM_DEPTH);
    case (ir_type_t'(w[31:28]))
      T_ALU:   push_wb(ra, model_alu(w[26:24], a, b));
      T_MOV:   push_wb(ra, a);
      T_LDI:   push_wb(ra, imm);
      T_LOAD:  push_wb(ra, mmem[addr]);
      T_STORE: mmem[addr] = mregs[ra];
      default: ;
    endcase
  endtask

  // ************************************************************
  // checks and waits
  // ************************************************************

  task automatic check_ready(input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: in_ready is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_wb(input pipe_pkg::wb_t got, input pipe_pkg::wb_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: write-back r%0d=%h, expected r%0d=%h",
               $time, got.addr, got.data, exp.addr, exp.data);
    end
  endtask

  always @(negedge clk_i)
  begin
    if (arst_n && wb.write)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("unexpected write-back to r%0d at %0t ns", wb.addr, $time);
      end
      else
        check_wb(wb, exp_q.pop_front());
    end
  end

  // offer one word and hold it at the port until it is taken
  task automatic issue(input ir_t w);
    int   waited;
    logic took;
    waited   = 0;
    took     = 1'b0;
    in_valid = 1'b1;
    in_ir    = w;
    while (!took && waited < 200)
    begin
      @(negedge clk_i);
      check_ready(in_ready, !load_use(id_word, w));
      took = in_ready;  // follow the DUT so the model stays in step
      @(posedge clk_i);
      if (took)
      begin
        model_exec(w);
        id_word = w;
      end
      else
      begin
        id_word = '0;
        stalls++;
        waited++;
      end
      #2;
    end
    in_valid = 1'b0;
    if (!took)
    begin
      $display("timeout: in_ready stayed low for 200 cycles on word %h", w);
      $display("CHECKS FAILED");
      $finish;
    end
  endtask

  task automatic idle(input int n);
    in_valid = 1'b0;
    in_ir    = '0;
    repeat (n)
    begin
      @(negedge clk_i);
      check_ready(in_ready, 1'b1);
      @(posedge clk_i);
      id_word = '0;
      #2;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 200)
    begin
      idle(1);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout: %0d expected write-backs never arrived in 200 cycles", exp_q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  endtask

  task automatic end_test(input int num, input string name);
    drain();
    $display("test %0d %s: %0d checks, %0d errors, %0d stall cycles", num, name,
             checks - chk_mark, errors - err_mark, stalls - stall_mark);
    chk_mark   = checks;
    err_mark   = errors;
    stall_mark = stalls;
  endtask

  // ************************************************************
  // tests
  // ************************************************************

  initial
  begin
    reg_addr_t x, k, d, base;
    data_t     addr;
    logic      absf;
    int unsigned gap;
    clk_i      = 1'b0;
    arst_n     = 1'b0;
    in_valid   = 1'b0;
    in_ir      = '0;
    seed       = 74;
    checks     = 0;
    errors     = 0;
    stalls     = 0;
    chk_mark   = 0;
    err_mark   = 0;
    stall_mark = 0;
    id_word    = '0;
    mregs      = '{default: '0};
    mmem       = '{default: '0};
    repeat (5) @(posedge clk_i);
    #2;
    arst_n = 1'b1;

    for (int r = 0; r < 4; r++)
      issue(enc(T_LDI, 4'd0, reg_addr_t'(r), 4'd0, 4'd0, 1'b0, rnd_word()));
    repeat (300)
      issue(rand_ir(T_ALU, 4));  // four registers keep every op dependent
    end_test(1, "distance-one chains");

    repeat (100)
    begin
      x = rnd_reg(4);
      issue(enc(T_ALU, {1'b1, 3'(rnd(7))}, x, rnd_reg(4), 4'd0, 1'b0, rnd_word()));
      gap = rnd(4);
      if (gap < 2)
        repeat (gap + 1)
          issue(enc(T_LDI, 4'd0, reg_addr_t'(8 + rnd(8)), 4'd0, 4'd0, 1'b0, rnd_word()));
      else
        idle(int'(gap) - 1);
      issue(enc(T_ALU, {1'b0, 3'(rnd(7))}, rnd_reg(4), x, rnd_reg(4), 1'b0, '0));
    end
    end_test(2, "distance-two and three");

    repeat (100)
    begin
      k    = reg_addr_t'(4 + rnd(4));
      d    = rnd_reg(4);
      addr = data_t'(rnd(`PIPE_DMEM_DEPTH));
      issue(enc(T_LDI, 4'd0, k, 4'd0, 4'd0, 1'b0, rnd_word()));
      issue(enc(T_STORE, 4'd0, k, 4'd0, 4'd0, 1'b1, addr));
      issue(enc(T_LOAD, 4'd0, d, 4'd0, 4'd0, 1'b1, addr));
      if (rnd(2) == 0)
        issue(enc(T_ALU, 4'd0, rnd_reg(4), d, rnd_reg(4), 1'b0, '0));  // reads the load result
      else
        issue(enc(T_ALU, 4'd0, reg_addr_t'(8 + rnd(8)), reg_addr_t'(8 + rnd(8)),
                  reg_addr_t'(8 + rnd(8)), 1'b0, '0));  // reads only other registers
    end
    end_test(3, "load-use stall");

    repeat (100)
    begin
      k    = reg_addr_t'(4 + rnd(4));
      base = rnd_reg(4);
      absf = 1'(rnd(2));
      addr = rnd_word();
      issue(enc(T_ALU, {1'b1, 3'(rnd(7))}, k, rnd_reg(4), 4'd0, 1'b0, rnd_word()));
      issue(enc(T_STORE, 4'd0, k, base, 4'd0, absf, addr));
      issue(enc(T_LOAD, 4'd0, rnd_reg(4), base, 4'd0, absf, addr));
      issue(enc(T_LOAD, 4'd0, rnd_reg(4), 4'd0, 4'd0, 1'b1, rnd_word()));
    end
    end_test(4, "store then load");

    repeat (2000)
    begin
      if (rnd(8) == 0)
        idle(1 + int'(rnd(3)));
      issue(rand_ir(ir_type_t'(rnd(5)), 16));
    end
    end_test(5, "long random stream");

    idle(5);  // room for a stray write-back to show up
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
